// File: source/exu_pkg.sv
package exu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [9:0]  alu_op_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [1:0]  src1_sel_t;
    typedef logic [2:0]  src2_sel_t;
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [1:0]  axi_resp_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;

    // one-hot alu ops with add in bit 0
    localparam alu_op_t ALU_ADD  = 10'b00_0000_0001;
    localparam alu_op_t ALU_SUB  = 10'b00_0000_0010;
    localparam alu_op_t ALU_SLT  = 10'b00_0000_0100;
    localparam alu_op_t ALU_SLTU = 10'b00_0000_1000;
    localparam alu_op_t ALU_XOR  = 10'b00_0001_0000;
    localparam alu_op_t ALU_OR   = 10'b00_0010_0000;
    localparam alu_op_t ALU_AND  = 10'b00_0100_0000;
    localparam alu_op_t ALU_SLL  = 10'b00_1000_0000;
    localparam alu_op_t ALU_SRL  = 10'b01_0000_0000;
    localparam alu_op_t ALU_SRA  = 10'b10_0000_0000;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'd0;
    localparam funct3_t F3_BNE  = 3'd1;
    localparam funct3_t F3_BLT  = 3'd4;
    localparam funct3_t F3_BGE  = 3'd5;
    localparam funct3_t F3_BLTU = 3'd6;
    localparam funct3_t F3_BGEU = 3'd7;

    // load/store sizes
    localparam funct3_t F3_B  = 3'd0;
    localparam funct3_t F3_H  = 3'd1;
    localparam funct3_t F3_W  = 3'd2;
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

    localparam axi_size_t  AXI_SIZE_WORD  = 3'd2;
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;
    localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;

    typedef struct packed {
        word_t     src1;
        word_t     src2;
        word_t     pc;
        word_t     imm;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        alu_op_t   alu_op;
        funct3_t   funct3;
        logic      load;
        logic      store;
        logic      brch;
        logic      jal;
        logic      jalr;
        logic      ecall;
        logic      mret;
    } exu_ctrl_t;

    typedef struct packed {
        word_t res;
        logic  brch_taken;
        word_t pc_next;
    } exu_out_t;

    typedef struct packed {
        word_t      addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        axi_id_t    id;
        logic       valid;
    } axi_aw_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
        logic  valid;
    } axi_w_t;

    typedef struct packed {
        axi_resp_t resp;
        axi_id_t   id;
        logic      valid;
    } axi_b_t;

    typedef struct packed {
        word_t      addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        axi_id_t    id;
        logic       valid;
    } axi_ar_t;

    typedef struct packed {
        word_t     data;
        axi_resp_t resp;
        axi_id_t   id;
        logic      last;
        logic      valid;
    } axi_r_t;

endpackage

// File: source/exu_alu.sv
module exu_alu import exu_pkg::*; (
    input  word_t   i_src1,
    input  word_t   i_src2,
    input  alu_op_t i_op,
    output word_t   o_res
);

    logic [4:0] shamt;

    assign shamt = i_src2[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD: begin
                o_res = i_src1 + i_src2;
            end
            ALU_SUB: begin
                o_res = i_src1 - i_src2;
            end
            ALU_SLT: begin
                o_res = {31'd0, $signed(i_src1) < $signed(i_src2)};
            end
            ALU_SLTU: begin
                o_res = {31'd0, i_src1 < i_src2};
            end
            ALU_XOR: begin
                o_res = i_src1 ^ i_src2;
            end
            ALU_OR: begin
                o_res = i_src1 | i_src2;
            end
            ALU_AND: begin
                o_res = i_src1 & i_src2;
            end
            ALU_SLL: begin
                o_res = i_src1 << shamt;
            end
            ALU_SRL: begin
                o_res = i_src1 >> shamt;
            end
            ALU_SRA: begin
                o_res = $signed(i_src1) >>> shamt;
            end
            // no op or more than one bit set
            default: begin
                o_res = '0;
            end
        endcase
    end

endmodule

// File: source/exu_lsu.sv
module exu_lsu import exu_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    i_start,
    input  logic    i_load,
    input  word_t   i_addr,
    input  word_t   i_store_data,
    input  funct3_t i_funct3,
    output logic    o_done,
    output word_t   o_load_data,
    output axi_aw_t o_aw,
    input  logic    i_aw_ready,
    output axi_w_t  o_w,
    input  logic    i_w_ready,
    input  axi_b_t  i_b,
    output logic    o_b_ready,
    output axi_ar_t o_ar,
    input  logic    i_ar_ready,
    input  axi_r_t  i_r,
    output logic    o_r_ready
);

    typedef enum logic [1:0] {
        L_IDLE,
        L_ADDR,
        L_RESP,
        L_READ
    } lsu_state_t;

    lsu_state_t state;
    word_t      addr_q;
    word_t      data_q;
    funct3_t    f3_q;
    logic       ld_q;
    logic       aw_done;
    logic       w_done;
    logic       aw_hs;
    logic       w_hs;
    logic [4:0] lane_shift;
    strb_t      base_strb;
    word_t      rd_shifted;

    // byte offset in bits
    assign lane_shift = {addr_q[1:0], 3'b000};

    always_comb begin
        case (f3_q)
            F3_B, F3_BU: base_strb = 4'b0001;
            F3_H, F3_HU: base_strb = 4'b0011;
            default:     base_strb = 4'b1111;
        endcase
    end

    always_comb begin
        o_aw       = '0;
        o_aw.addr  = addr_q;
        o_aw.size  = AXI_SIZE_WORD;
        o_aw.burst = AXI_BURST_INCR;
        o_aw.valid = (state == L_ADDR) && !ld_q && !aw_done;
        o_ar       = '0;
        o_ar.addr  = addr_q;
        o_ar.size  = AXI_SIZE_WORD;
        o_ar.burst = AXI_BURST_INCR;
        o_ar.valid = (state == L_ADDR) && ld_q;
        o_w.data   = data_q << lane_shift;
        o_w.strb   = base_strb << addr_q[1:0];
        o_w.last   = 1'b1;
        o_w.valid  = (state == L_ADDR) && !ld_q && !w_done;
    end

    assign o_b_ready = 1'b1;
    assign o_r_ready = 1'b1;
    assign aw_hs     = o_aw.valid && i_aw_ready;
    assign w_hs      = o_w.valid && i_w_ready;
    assign o_done    = ((state == L_RESP) && i_b.valid) || ((state == L_READ) && i_r.valid);

    // pick the addressed lane, then extend
    assign rd_shifted = i_r.data >> lane_shift;
    always_comb begin
        case (f3_q)
            F3_B:    o_load_data = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
            F3_H:    o_load_data = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
            F3_BU:   o_load_data = {24'd0, rd_shifted[7:0]};
            F3_HU:   o_load_data = {16'd0, rd_shifted[15:0]};
            default: o_load_data = i_r.data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (i_start) begin
            addr_q <= i_addr;
            data_q <= i_store_data;
            f3_q   <= i_funct3;
            ld_q   <= i_load;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= L_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                L_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (i_start) begin
                        state <= L_ADDR;
                    end
                end
                L_ADDR: begin
                    if (ld_q) begin
                        if (i_ar_ready) begin
                            state <= L_READ;
                        end
                    end else begin
                        aw_done <= aw_done || aw_hs;
                        w_done  <= w_done || w_hs;
                        if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                            state <= L_RESP;
                        end
                    end
                end
                L_RESP: begin
                    if (i_b.valid) begin
                        state <= L_IDLE;
                    end
                end
                default: begin
                    if (i_r.valid) begin
                        state <= L_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: source/exu.sv
module exu import exu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  exu_ctrl_t i_ctrl,
    input  logic      i_pre_valid,
    output logic      o_pre_ready,
    output exu_out_t  o_out,
    output logic      o_post_valid,
    input  logic      i_post_ready,
    output axi_aw_t   o_aw,
    input  logic      i_aw_ready,
    output axi_w_t    o_w,
    input  logic      i_w_ready,
    input  axi_b_t    i_b,
    output logic      o_b_ready,
    output axi_ar_t   o_ar,
    input  logic      i_ar_ready,
    input  axi_r_t    i_r,
    output logic      o_r_ready
);

    typedef enum logic {
        S_IDLE,
        S_MEM
    } exu_state_t;

    exu_state_t state;
    exu_out_t   out_q;
    logic       post_valid_q;
    logic       ld_q;
    word_t      alu_src1;
    word_t      alu_src2;
    word_t      alu_res;
    word_t      load_data;
    word_t      pc_next;
    logic       brch_cond;
    logic       brch_taken;
    logic       accept;
    logic       is_mem;
    logic       lsu_start;
    logic       lsu_done;

    always_comb begin
        if (i_ctrl.src1_sel[0]) begin
            alu_src1 = i_ctrl.src1;
        end else begin
            alu_src1 = i_ctrl.pc;
        end
        case (1'b1)
            i_ctrl.src2_sel[0]: alu_src2 = i_ctrl.src2;
            i_ctrl.src2_sel[1]: alu_src2 = i_ctrl.imm;
            i_ctrl.src2_sel[2]: alu_src2 = 32'd4;
            default:            alu_src2 = '0;
        endcase
    end

    exu_alu u_alu (
        .i_src1 (alu_src1),
        .i_src2 (alu_src2),
        .i_op   (i_ctrl.alu_op),
        .o_res  (alu_res)
    );

    // orderings rely on the alu running slt or sltu
    always_comb begin
        case (i_ctrl.funct3)
            F3_BEQ:          brch_cond = (alu_src1 == alu_src2);
            F3_BNE:          brch_cond = (alu_src1 != alu_src2);
            F3_BLT, F3_BLTU: brch_cond = alu_res[0];
            F3_BGE, F3_BGEU: brch_cond = ~alu_res[0];
            default:         brch_cond = 1'b0;
        endcase
    end

    assign brch_taken = i_ctrl.brch && brch_cond;

    always_comb begin
        if (i_ctrl.jal || brch_taken) begin
            pc_next = i_ctrl.pc + i_ctrl.imm;
        end else if (i_ctrl.jalr) begin
            pc_next = i_ctrl.src1 + i_ctrl.imm;
        end else if (i_ctrl.ecall || i_ctrl.mret) begin
            pc_next = i_ctrl.src1;
        end else begin
            pc_next = i_ctrl.pc + 32'd4;
        end
    end

    assign o_pre_ready = (state == S_IDLE) && !post_valid_q;
    assign accept      = i_pre_valid && o_pre_ready;
    assign is_mem      = i_ctrl.load || i_ctrl.store;
    assign lsu_start   = accept && is_mem;

    exu_lsu u_lsu (
        .clock        (clock),
        .reset        (reset),
        .i_start      (lsu_start),
        .i_load       (i_ctrl.load),
        .i_addr       (alu_res),
        .i_store_data (i_ctrl.src2),
        .i_funct3     (i_ctrl.funct3),
        .o_done       (lsu_done),
        .o_load_data  (load_data),
        .o_aw         (o_aw),
        .i_aw_ready   (i_aw_ready),
        .o_w          (o_w),
        .i_w_ready    (i_w_ready),
        .i_b          (i_b),
        .o_b_ready    (o_b_ready),
        .o_ar         (o_ar),
        .i_ar_ready   (i_ar_ready),
        .i_r          (i_r),
        .o_r_ready    (o_r_ready)
    );

    // memory ops keep the sequential pc and loads patch res on completion
    always_ff @(posedge clock) begin
        if (accept) begin
            out_q.res        <= alu_res;
            out_q.brch_taken <= brch_taken;
            out_q.pc_next    <= pc_next;
            ld_q             <= i_ctrl.load;
        end else if (lsu_done && ld_q) begin
            out_q.res <= load_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= S_IDLE;
            post_valid_q <= 1'b0;
        end else begin
            if (lsu_start) begin
                state <= S_MEM;
            end else if (lsu_done) begin
                state <= S_IDLE;
            end
            if ((accept && !is_mem) || lsu_done) begin
                post_valid_q <= 1'b1;
            end else if (i_post_ready) begin
                post_valid_q <= 1'b0;
            end
        end
    end

    assign o_out        = out_q;
    assign o_post_valid = post_valid_q;

endmodule

// File: source/data_sram.sv
module data_sram import exu_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  logic    clock,
    input  logic    reset,
    input  axi_aw_t i_aw,
    output logic    o_aw_ready,
    input  axi_w_t  i_w,
    output logic    o_w_ready,
    output axi_b_t  o_b,
    input  logic    i_b_ready,
    input  axi_ar_t i_ar,
    output logic    o_ar_ready,
    output axi_r_t  o_r,
    input  logic    i_r_ready
);

    word_t mem [MEM_WORDS];
    word_t aw_addr_q;
    word_t w_data_q;
    strb_t w_strb_q;
    word_t r_data_q;
    logic  aw_have;
    logic  w_have;
    logic  b_valid;
    logic  r_valid;
    logic  aw_hs;
    logic  w_hs;
    logic  wr_go;
    word_t wr_addr;
    word_t wr_data;
    strb_t wr_strb;
    word_t wr_idx;
    word_t rd_idx;

    assign o_aw_ready = !aw_have && !b_valid;
    assign o_w_ready  = !w_have && !b_valid;
    assign o_ar_ready = !r_valid;
    assign aw_hs      = i_aw.valid && o_aw_ready;
    assign w_hs       = i_w.valid && o_w_ready;

    // write once both halves have arrived by this edge
    assign wr_go   = (aw_have || aw_hs) && (w_have || w_hs);
    assign wr_addr = aw_have ? aw_addr_q : i_aw.addr;
    assign wr_data = w_have ? w_data_q : i_w.data;
    assign wr_strb = w_have ? w_strb_q : i_w.strb;
    assign wr_idx  = (wr_addr >> 2) % MEM_WORDS;
    assign rd_idx  = (i_ar.addr >> 2) % MEM_WORDS;

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            aw_addr_q <= i_aw.addr;
        end
        if (w_hs) begin
            w_data_q <= i_w.data;
            w_strb_q <= i_w.strb;
        end
        if (wr_go) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
        if (i_ar.valid && o_ar_ready) begin
            r_data_q <= mem[rd_idx];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_go) begin
                aw_have <= 1'b0;
                w_have  <= 1'b0;
                b_valid <= 1'b1;
            end else begin
                aw_have <= aw_have || aw_hs;
                w_have  <= w_have || w_hs;
                if (i_b_ready) begin
                    b_valid <= 1'b0;
                end
            end
            if (i_ar.valid && o_ar_ready) begin
                r_valid <= 1'b1;
            end else if (i_r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    assign o_b = '{resp: AXI_RESP_OKAY, id: '0, valid: b_valid};
    assign o_r = '{data: r_data_q, resp: AXI_RESP_OKAY, id: '0, last: 1'b1, valid: r_valid};

endmodule

// File: source/exu_top.sv
module exu_top import exu_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  logic      clock,
    input  logic      reset,
    input  exu_ctrl_t i_ctrl,
    input  logic      i_pre_valid,
    output logic      o_pre_ready,
    output exu_out_t  o_out,
    output logic      o_post_valid,
    input  logic      i_post_ready
);

    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;
    axi_ar_t ar;
    axi_r_t  r;
    logic    aw_ready;
    logic    w_ready;
    logic    b_ready;
    logic    ar_ready;
    logic    r_ready;

    exu u_exu (
        .clock        (clock),
        .reset        (reset),
        .i_ctrl       (i_ctrl),
        .i_pre_valid  (i_pre_valid),
        .o_pre_ready  (o_pre_ready),
        .o_out        (o_out),
        .o_post_valid (o_post_valid),
        .i_post_ready (i_post_ready),
        .o_aw         (aw),
        .i_aw_ready   (aw_ready),
        .o_w          (w),
        .i_w_ready    (w_ready),
        .i_b          (b),
        .o_b_ready    (b_ready),
        .o_ar         (ar),
        .i_ar_ready   (ar_ready),
        .i_r          (r),
        .o_r_ready    (r_ready)
    );

    // data memory on the lsu's master port
    data_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clock      (clock),
        .reset      (reset),
        .i_aw       (aw),
        .o_aw_ready (aw_ready),
        .i_w        (w),
        .o_w_ready  (w_ready),
        .o_b        (b),
        .i_b_ready  (b_ready),
        .i_ar       (ar),
        .o_ar_ready (ar_ready),
        .o_r        (r),
        .i_r_ready  (r_ready)
    );

endmodule

// File: sim/exu_top_assertions.sv
module exu_top_assertions import exu_pkg::*; (
    input logic      clock,
    input logic      reset,
    input exu_ctrl_t i_ctrl,
    input logic      i_pre_valid,
    input logic      o_pre_ready,
    input exu_out_t  o_out,
    input logic      o_post_valid,
    input logic      i_post_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    int       fail_count = 0;
    logic     accept;
    logic     is_mem;
    word_t    op_a;
    word_t    op_b;
    logic     cond;
    word_t    exp_res;
    logic     exp_taken;
    word_t    exp_pc;
    logic     chk_q;
    word_t    exp_res_q;
    logic     exp_taken_q;
    word_t    exp_pc_q;
    logic     stall_q;
    exu_out_t out_prev;
    logic     mem_busy;
    logic     reset_q;

    assign accept = i_pre_valid && o_pre_ready;
    assign is_mem = i_ctrl.load || i_ctrl.store;
    assign op_a   = i_ctrl.src1_sel[0] ? i_ctrl.src1 : i_ctrl.pc;

    // reference model of the instruction rules
    always_comb begin
        case (i_ctrl.src2_sel)
            3'b001:  op_b = i_ctrl.src2;
            3'b010:  op_b = i_ctrl.imm;
            3'b100:  op_b = 32'd4;
            default: op_b = '0;
        endcase
        case (i_ctrl.alu_op)
            ALU_ADD:  exp_res = op_a + op_b;
            ALU_SUB:  exp_res = op_a - op_b;
            ALU_SLT:  exp_res = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            ALU_SLTU: exp_res = (op_a < op_b) ? 32'd1 : 32'd0;
            ALU_XOR:  exp_res = op_a ^ op_b;
            ALU_OR:   exp_res = op_a | op_b;
            ALU_AND:  exp_res = op_a & op_b;
            ALU_SLL:  exp_res = op_a << op_b[4:0];
            ALU_SRL:  exp_res = op_a >> op_b[4:0];
            ALU_SRA:  exp_res = word_t'($signed(op_a) >>> op_b[4:0]);
            default:  exp_res = '0;
        endcase
        case (i_ctrl.funct3)
            F3_BEQ:  cond = (op_a == op_b);
            F3_BNE:  cond = (op_a != op_b);
            F3_BLT:  cond = ($signed(op_a) < $signed(op_b));
            F3_BGE:  cond = ($signed(op_a) >= $signed(op_b));
            F3_BLTU: cond = (op_a < op_b);
            F3_BGEU: cond = (op_a >= op_b);
            default: cond = 1'b0;
        endcase
        exp_taken = i_ctrl.brch && cond;
        if (i_ctrl.jal || exp_taken) begin
            exp_pc = i_ctrl.pc + i_ctrl.imm;
        end else if (i_ctrl.jalr) begin
            exp_pc = i_ctrl.src1 + i_ctrl.imm;
        end else if (i_ctrl.ecall || i_ctrl.mret) begin
            exp_pc = i_ctrl.src1;
        end else begin
            exp_pc = i_ctrl.pc + 32'd4;
        end
    end

    always_ff @(posedge clock) begin
        chk_q       <= !reset && accept && !is_mem;
        exp_res_q   <= exp_res;
        exp_taken_q <= exp_taken;
        exp_pc_q    <= exp_pc;
        stall_q     <= !reset && o_post_valid && !i_post_ready;
        out_prev    <= o_out;
        reset_q     <= reset;
        if (reset || o_post_valid) begin
            mem_busy <= 1'b0;
        end else if (accept && is_mem) begin
            mem_busy <= 1'b1;
        end
    end

    a_valid_next: assert property (@(posedge clock) chk_q |-> o_post_valid)
        else begin
            fail_count++;
            $error("result valid did not rise one cycle after acceptance");
        end

    a_res: assert property (@(posedge clock) chk_q |-> o_out.res == exp_res_q)
        else begin
            fail_count++;
            $error("ERR alu_res expected %h actual %h", $sampled(exp_res_q),
                   $sampled(o_out.res));
        end

    a_taken: assert property (@(posedge clock) chk_q |-> o_out.brch_taken == exp_taken_q)
        else begin
            fail_count++;
            $error("ERR brch_taken expected %b actual %b", $sampled(exp_taken_q),
                   $sampled(o_out.brch_taken));
        end

    a_pc_next: assert property (@(posedge clock) chk_q |-> o_out.pc_next == exp_pc_q)
        else begin
            fail_count++;
            $error("ERR pc_next expected %h actual %h", $sampled(exp_pc_q),
                   $sampled(o_out.pc_next));
        end

    a_hold: assert property (@(posedge clock) stall_q |-> o_post_valid && o_out == out_prev)
        else begin
            fail_count++;
            $error("result changed or vanished while the consumer was stalled");
        end

    a_full_blocks: assert property (@(posedge clock) o_post_valid |-> !o_pre_ready)
        else begin
            fail_count++;
            $error("stage was ready while a result was still waiting");
        end

    a_mem_busy: assert property (@(posedge clock) mem_busy |-> !o_pre_ready)
        else begin
            fail_count++;
            $error("stage was ready during a memory access");
        end

    a_reset: assert property (@(posedge clock) reset_q |-> !o_post_valid && o_pre_ready)
        else begin
            fail_count++;
            $error("handshake outputs wrong after reset");
        end

endmodule

bind exu_top exu_top_assertions u_asrt (
    .clock        (clock),
    .reset        (reset),
    .i_ctrl       (i_ctrl),
    .i_pre_valid  (i_pre_valid),
    .o_pre_ready  (o_pre_ready),
    .o_out        (o_out),
    .o_post_valid (o_post_valid),
    .i_post_ready (i_post_ready)
);

// File: sim/exu_top_tb.sv
module exu_top_tb import exu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic       clock;
    logic       reset;
    exu_ctrl_t  i_ctrl;
    logic       i_pre_valid;
    logic       o_pre_ready;
    exu_out_t   o_out;
    logic       o_post_valid;
    logic       i_post_ready;
    int         errors;
    int         sent;
    int         taken;
    logic [7:0] shadow [4096];

    exu_top #(
        .MEM_WORDS (1024)
    ) u_dut (
        .clock        (clock),
        .reset        (reset),
        .i_ctrl       (i_ctrl),
        .i_pre_valid  (i_pre_valid),
        .o_pre_ready  (o_pre_ready),
        .o_out        (o_out),
        .o_post_valid (o_post_valid),
        .i_post_ready (i_post_ready)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // count handshakes as the ports show them
    always @(posedge clock) begin
        if (!reset && i_pre_valid && o_pre_ready) begin
            sent++;
        end
        if (!reset && o_post_valid && i_post_ready) begin
            taken++;
        end
    end

    function automatic exu_ctrl_t random_ctrl();
        exu_ctrl_t c;
        c      = '0;
        c.src1 = $urandom();
        c.src2 = $urandom();
        c.pc   = $urandom() & 32'hffff_fffc;
        c.imm  = $urandom();
        return c;
    endfunction

    // runs one instruction through the stage from 2 ns after an edge
    task automatic execute(input exu_ctrl_t c, output exu_out_t r);
        int wait_cnt;
        int stall;
        i_ctrl      = c;
        i_pre_valid = 1'b1;
        wait_cnt    = 0;
        while (!o_pre_ready && wait_cnt < 50) begin
            @(posedge clock);
            #2;
            wait_cnt++;
        end
        if (!o_pre_ready) begin
            $display("timeout: the stage never became ready for an instruction");
            errors++;
        end
        @(posedge clock);
        #2;
        i_pre_valid = 1'b0;
        wait_cnt = 0;
        while (!o_post_valid && wait_cnt < 50) begin
            @(posedge clock);
            #2;
            wait_cnt++;
        end
        if (!o_post_valid) begin
            $display("timeout: no result came back from the stage");
            errors++;
            r = '0;
        end else begin
            // hold the consumer off for a while
            stall = $urandom_range(0, 4);
            repeat (stall) begin
                @(posedge clock);
                #2;
            end
            r            = o_out;
            i_post_ready = 1'b1;
            @(posedge clock);
            #2;
            i_post_ready = 1'b0;
            if (o_post_valid) begin
                $display("the result stayed valid after it was taken");
                errors++;
            end
        end
    endtask

    task automatic alu_tests();
        exu_ctrl_t c;
        exu_out_t  r;
        for (int op = 0; op < 10; op++) begin
            for (int k = 0; k < 40; k++) begin
                c          = random_ctrl();
                c.alu_op   = alu_op_t'(1 << op);
                c.src1_sel = src1_sel_t'($urandom_range(0, 3));
                case ($urandom_range(0, 3))
                    0:       c.src2_sel = 3'b000;
                    1:       c.src2_sel = 3'b001;
                    2:       c.src2_sel = 3'b010;
                    default: c.src2_sel = 3'b100;
                endcase
                execute(c, r);
            end
        end
    endtask

    task automatic branch_tests();
        exu_ctrl_t c;
        exu_out_t  r;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            for (int k = 0; k < 24; k++) begin
                c          = random_ctrl();
                c.brch     = 1'b1;
                c.funct3   = funct3_t'(f);
                c.src1_sel = 2'b01;
                c.src2_sel = 3'b001;
                if (k % 3 == 0) begin
                    c.src2 = c.src1;
                end else if (k % 3 == 1) begin
                    c.src2 = c.src1 ^ 32'h8000_0000;
                end
                case (c.funct3)
                    F3_BLT, F3_BGE:   c.alu_op = ALU_SLT;
                    F3_BLTU, F3_BGEU: c.alu_op = ALU_SLTU;
                    default:          c.alu_op = ALU_SUB;
                endcase
                execute(c, r);
            end
        end
    endtask

    task automatic jump_tests();
        exu_ctrl_t c;
        exu_out_t  r;
        for (int k = 0; k < 40; k++) begin
            c          = random_ctrl();
            c.alu_op   = ALU_ADD;
            c.src1_sel = 2'b00;
            c.src2_sel = 3'b100;
            case (k % 4)
                0:       c.jal = 1'b1;
                1:       c.jalr = 1'b1;
                2:       c.ecall = 1'b1;
                default: c.mret = 1'b1;
            endcase
            execute(c, r);
        end
    endtask

    task automatic memory_op(input word_t addr, input funct3_t f3, input logic ld,
                             input word_t data, output exu_out_t r);
        exu_ctrl_t c;
        c          = random_ctrl();
        c.src1     = addr & 32'hffff_fffc;
        c.imm      = addr & 32'd3;
        c.src2     = data;
        c.src1_sel = 2'b01;
        c.src2_sel = 3'b010;
        c.alu_op   = ALU_ADD;
        c.funct3   = f3;
        c.load     = ld;
        c.store    = !ld;
        execute(c, r);
    endtask

    task automatic store(input word_t addr, input funct3_t f3, input word_t data);
        exu_out_t r;
        int       n;
        n = (f3 == F3_B) ? 1 : (f3 == F3_H) ? 2 : 4;
        memory_op(addr, f3, 1'b0, data, r);
        for (int i = 0; i < n; i++) begin
            shadow[int'(addr[11:0]) + i] = data[8*i +: 8];
        end
    endtask

    task automatic load_check(input word_t addr, input funct3_t f3);
        exu_out_t r;
        word_t    exp;
        int       a;
        a = int'(addr[11:0]);
        case (f3)
            F3_B:    exp = {{24{shadow[a][7]}}, shadow[a]};
            F3_BU:   exp = {24'd0, shadow[a]};
            F3_H:    exp = {{16{shadow[a+1][7]}}, shadow[a+1], shadow[a]};
            F3_HU:   exp = {16'd0, shadow[a+1], shadow[a]};
            default: exp = {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
        endcase
        memory_op(addr, f3, 1'b1, $urandom(), r);
        if (r.res !== exp) begin
            $display("ERR load_f3_%0d at %h expected %h actual %h", f3, addr, exp, r.res);
            errors++;
        end
    endtask

    task automatic memory_tests();
        word_t base;
        word_t hoff;
        word_t boff;
        for (int k = 0; k < 12; k++) begin
            base = word_t'($urandom_range(0, 1023)) << 2;
            hoff = word_t'($urandom_range(0, 1)) << 1;
            boff = word_t'($urandom_range(0, 3));
            store(base, F3_W, $urandom());
            store(base + hoff, F3_H, $urandom());
            store(base + boff, F3_B, $urandom());
            load_check(base, F3_W);
            load_check(base + hoff, F3_H);
            load_check(base + (hoff ^ 32'd2), F3_HU);
            load_check(base + boff, F3_B);
            load_check(base + (boff ^ 32'd1), F3_BU);
        end
    endtask

    initial begin
        void'($urandom(32'h6ddf9b87));
        errors       = 0;
        sent         = 0;
        taken        = 0;
        reset        = 1'b1;
        i_ctrl       = '0;
        i_pre_valid  = 1'b0;
        i_post_ready = 1'b0;
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        alu_tests();
        branch_tests();
        jump_tests();
        memory_tests();
        repeat (2) @(posedge clock);
        #2;
        if (sent != taken) begin
            $display("%0d instructions accepted but %0d results taken", sent, taken);
            errors++;
        end
        $display("errors: %0d, assertion failures: %0d", errors, u_dut.u_asrt.fail_count);
        if (errors == 0 && u_dut.u_asrt.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: exu_top.f
source/exu_pkg.sv
source/exu_alu.sv
source/exu_lsu.sv
source/exu.sv
source/data_sram.sv
source/exu_top.sv
sim/exu_top_assertions.sv
sim/exu_top_tb.sv

// File: Makefile
SIM := obj_dir/Vexu_top_tb

all: run

$(SIM): exu_top.f $(wildcard source/*.sv sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f exu_top.f --top-module exu_top_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	! grep -q '>>> FAIL' sim.log && grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
